//--- Bender.yml
package:
  name: br_recovery

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/br_pkg.sv
      - verilog/recover_if.sv
      - verilog/psel_gen.sv
      - verilog/map_table.sv
      - verilog/br_stack.sv
      - verilog/br_recovery_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clock.sv
      - tb/br_assertions.sv
      - tb/br_tb.sv

//--- tb.f
+incdir+verilog
verilog/br_pkg.sv
verilog/recover_if.sv
verilog/psel_gen.sv
verilog/map_table.sv
verilog/br_stack.sv
verilog/br_recovery_top.sv
tb/tb_clock.sv
tb/br_assertions.sv
tb/br_tb.sv

//--- tb/br_assertions.sv
`timescale 1ns/1ps
`include "br_settings.svh"

module br_assertions (
    input logic                                clock,
    input logic                                reset,
    input br_pkg::checkpoint_t [`BR_DEPTH-1:0] entries,
    input logic                                full,
    input logic [`BR_DEPTH-1:0]                assigned_b_id,
    input br_pkg::br_task_e                    br_task,
    input logic                                restore
);
    import br_pkg::*;

    logic [`BR_DEPTH-1:0] live;  // valid bit of each checkpoint

    int fail_count = 0;  // number of failed assertions so far

    always_comb begin
        for (int i = 0; i < `BR_DEPTH; i++) begin
            live[i] = entries[i].valid;
        end
    end

    full_matches_entries: assert property (@(posedge clock) disable iff (reset)
        full == (&live))
        else begin
            $error("full does not match the valid checkpoints");
            fail_count++;
        end

    b_id_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(assigned_b_id))
        else begin
            $error("assigned_b_id has more than one bit set");
            fail_count++;
        end

    // a squash blocks allocation in the same cycle
    no_alloc_in_squash: assert property (@(posedge clock) disable iff (reset)
        (br_task == BR_SQUASH) |-> (assigned_b_id == '0))
        else begin
            $error("branch allocated during a squash");
            fail_count++;
        end

    recover_needs_squash: assert property (@(posedge clock) disable iff (reset)
        restore |-> (br_task == BR_SQUASH))
        else begin
            $error("recover_valid high without a squash");
            fail_count++;
        end

endmodule

//--- tb/br_tb.sv
`timescale 1ns/1ps
`include "br_settings.svh"

module br_tb;
    import br_pkg::*;

    localparam int RANDOM_CYCLES = 2000;
    localparam int WAIT_LIMIT    = 20;  // cycles

    logic clock;
    logic reset = 1'b1;

    logic                         dispatch_valid;
    logic                         dispatch_is_branch;
    logic [`ADDR_W-1:0]           dispatch_pc;
    logic                         rename_valid;
    logic [`ARCH_W-1:0]           rename_arch;
    logic [`PREG_W-1:0]           rename_preg;
    logic [`FL_W-1:0]             fl_head;
    logic [`ROB_W-1:0]            rob_tail;
    cdb_packet_t [`CDB_WIDTH-1:0] cdb;
    br_task_e                     br_task;
    logic [`BR_DEPTH-1:0]         rem_b_id;
    logic [`ARCH_W-1:0]           src_arch;

    logic [`BR_DEPTH-1:0]         assigned_b_id;
    logic                         full;
    logic                         recover_valid;
    logic [`ADDR_W-1:0]           recover_pc;
    logic [`FL_W-1:0]             recover_fl_head;
    logic [`ROB_W-1:0]            recover_rob_tail;
    logic [`PREG_W-1:0]           src_preg;
    logic                         src_ready;

    map_array_t  mod_mt;               // model of the live map
    checkpoint_t mod_cp [`BR_DEPTH];   // model checkpoints where slot i holds b_id 1 << i

    logic [15:0] lfsr_state = 16'd37;

    tb_clock i_clock (
        .clock (clock)
    );

    br_recovery_top i_dut (.*);

    bind br_stack br_assertions i_assertions (
        .clock         (clock),
        .reset         (reset),
        .entries       (entries),
        .full          (full),
        .assigned_b_id (assigned_b_id),
        .br_task       (br_task),
        .restore       (rec.restore)
    );

    initial begin
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    function automatic int slot_of(input logic [`BR_DEPTH-1:0] id);
        int k;
        k = -1;
        for (int i = 0; i < `BR_DEPTH; i++) begin
            if (mod_cp[i].valid && mod_cp[i].b_id == id) k = i;
        end
        return k;
    endfunction

    function automatic int free_slot();
        int g;
        g = -1;
        for (int i = `BR_DEPTH - 1; i >= 0; i--) begin
            if (!mod_cp[i].valid) g = i;  // lowest free wins
        end
        return g;
    endfunction

    function automatic int live_count();
        int n;
        n = 0;
        for (int i = 0; i < `BR_DEPTH; i++) begin
            if (mod_cp[i].valid) n++;
        end
        return n;
    endfunction

    // first live b_id at or after slot start with wraparound
    function automatic logic [`BR_DEPTH-1:0] pick_live(input int start);
        logic [`BR_DEPTH-1:0] id;
        id = '0;
        for (int n = `BR_DEPTH - 1; n >= 0; n--) begin
            if (mod_cp[(start + n) % `BR_DEPTH].valid) begin
                id = mod_cp[(start + n) % `BR_DEPTH].b_id;
            end
        end
        return id;
    endfunction

    task automatic idle_inputs();
        dispatch_valid     = 1'b0;
        dispatch_is_branch = 1'b0;
        dispatch_pc        = '0;
        rename_valid       = 1'b0;
        rename_arch        = '0;
        rename_preg        = '0;
        fl_head            = '0;
        rob_tail           = '0;
        cdb                = '0;
        br_task            = BR_NONE;
        rem_b_id           = '0;
        src_arch           = '0;
    endtask

    task automatic send_branch(input logic [31:0] pc, input int fl, input int rob);
        dispatch_valid     = 1'b1;
        dispatch_is_branch = 1'b1;
        dispatch_pc        = pc;
        fl_head            = 5'(fl);
        rob_tail           = 4'(rob);
    endtask

    // compare every output with the model, then move the model past the edge
    task automatic check_and_advance();
        int                   g;
        int                   k;
        logic                 alloc;
        logic                 restore;
        logic [`BR_DEPTH-1:0] mask;
        checkpoint_t          sel;
        map_array_t           nmt;
        checkpoint_t          ncp [`BR_DEPTH];

        g       = free_slot();
        k       = slot_of(rem_b_id);
        alloc   = dispatch_valid && dispatch_is_branch && g >= 0 && br_task != BR_SQUASH;
        restore = (br_task == BR_SQUASH) && k >= 0;
        if (k >= 0) begin
            sel = mod_cp[k];
        end else begin
            sel = '0;
        end

        compare_value("full", full, g < 0);
        compare_value("assigned_b_id", assigned_b_id, alloc ? (1 << g) : 0);
        compare_value("recover_valid", recover_valid, restore);
        compare_value("recover_pc", recover_pc, sel.rec_pc);
        compare_value("recover_fl_head", recover_fl_head, sel.fl_head);
        compare_value("recover_rob_tail", recover_rob_tail, sel.rob_tail);
        compare_value("src_preg", src_preg, mod_mt[src_arch].preg);
        compare_value("src_ready", src_ready, mod_mt[src_arch].ready);
        compare_value("assertion failures", i_dut.i_br_stack.i_assertions.fail_count, 0);

        nmt = restore ? sel.rec_mt : mod_mt;
        for (int l = 0; l < `CDB_WIDTH; l++) begin
            if (cdb[l].valid && nmt[cdb[l].arch_idx].preg == cdb[l].preg) begin
                nmt[cdb[l].arch_idx].ready = 1'b1;
            end
        end
        if (rename_valid && !restore) begin  // rename loses to a squash and beats the CDB
            nmt[rename_arch].preg  = rename_preg;
            nmt[rename_arch].ready = 1'b0;
        end

        mask = '0;
        for (int i = 0; i < `BR_DEPTH; i++) begin
            ncp[i] = mod_cp[i];
            if (mod_cp[i].valid) begin
                for (int l = 0; l < `CDB_WIDTH; l++) begin
                    if (cdb[l].valid && mod_cp[i].rec_mt[cdb[l].arch_idx].preg == cdb[l].preg)
                        ncp[i].rec_mt[cdb[l].arch_idx].ready = 1'b1;
                end
                if (br_task == BR_CLEAR && mod_cp[i].b_id == rem_b_id) begin
                    ncp[i] = '0;
                end else begin
                    if (br_task == BR_CLEAR) ncp[i].b_mask = mod_cp[i].b_mask & ~rem_b_id;
                    if (br_task == BR_SQUASH && (mod_cp[i].b_mask & rem_b_id) != 0) ncp[i] = '0;
                    mask |= mod_cp[i].b_id;  // older live branches
                end
            end
        end

        if (alloc) begin
            ncp[g].valid    = 1'b1;
            ncp[g].b_id     = 4'(1 << g);
            ncp[g].b_mask   = mask | 4'(1 << g);
            ncp[g].rec_pc   = dispatch_pc;
            ncp[g].rec_mt   = mod_mt;  // map before the edge
            ncp[g].fl_head  = fl_head;
            ncp[g].rob_tail = rob_tail;
        end

        mod_mt = nmt;
        mod_cp = ncp;
    endtask

    task automatic cycle_start();
        @(posedge clock);
        #1;
        idle_inputs();
    endtask

    task automatic cycle_end();
        @(negedge clock);
        check_and_advance();
    endtask

    task automatic drain_stack();
        int t;
        t = 0;
        while (live_count() > 0 && t < WAIT_LIMIT) begin
            cycle_start();
            br_task  = BR_CLEAR;
            rem_b_id = pick_live(0);
            cycle_end();
            t++;
        end
        if (live_count() > 0) begin
            $display("timeout: the checkpoint stack did not drain");
            abort_run();
        end
    endtask

    task automatic drive_random();
        logic [2:0] pick;
        dispatch_valid     = 1'(take_bits(1));
        dispatch_is_branch = 1'(take_bits(1));
        dispatch_pc        = take_bits(14) << 2;
        rename_valid       = 1'(take_bits(1));
        rename_arch        = 3'(take_bits(3));
        rename_preg        = 4'(take_bits(4));
        fl_head            = 5'(take_bits(5));
        rob_tail           = 4'(take_bits(4));
        for (int l = 0; l < `CDB_WIDTH; l++) begin
            cdb[l].valid    = 1'(take_bits(1));
            cdb[l].arch_idx = 3'(take_bits(3));
            // half the lanes hit the current mapping so wakeups happen
            if (take_bits(1) != 0) begin
                cdb[l].preg = mod_mt[cdb[l].arch_idx].preg;
            end else begin
                cdb[l].preg = 4'(take_bits(4));
            end
        end
        src_arch = 3'(take_bits(3));
        pick     = 3'(take_bits(3));
        if (live_count() > 0 && pick < 3) begin
            br_task  = (pick == 0) ? BR_SQUASH : BR_CLEAR;
            rem_b_id = pick_live(int'(take_bits(2)));
        end
    endtask

    initial begin
        int t;

        idle_inputs();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            mod_mt[i].preg  = 4'(i);  // identity map after reset
            mod_mt[i].ready = 1'b1;
        end
        for (int i = 0; i < `BR_DEPTH; i++) begin
            mod_cp[i] = '0;
        end

        t = 0;
        while (reset && t < WAIT_LIMIT) begin
            @(posedge clock);
            t++;
        end
        if (reset) begin
            $display("timeout: reset was never released");
            abort_run();
        end

        // reset state
        for (int i = 0; i < `ARCH_REGS; i++) begin
            cycle_start();
            src_arch = 3'(i);
            cycle_end();
            compare_value("src_preg", src_preg, i);
            compare_value("src_ready", src_ready, 1);
        end
        compare_value("full", full, 0);
        compare_value("assigned_b_id", assigned_b_id, 0);

        // fill the stack so each snapshot sees one more rename
        for (int n = 0; n < `BR_DEPTH; n++) begin
            cycle_start();
            send_branch(32'h1000 + 4 * n, n + 1, 3 * n);
            rename_valid = 1'b1;
            rename_arch  = 3'(n);
            rename_preg  = 4'(8 + n);
            cycle_end();
            compare_value("assigned_b_id", assigned_b_id, 1 << n);
        end
        cycle_start();
        send_branch(32'h2000, 0, 0);
        cycle_end();
        compare_value("full", full, 1);
        compare_value("assigned_b_id", assigned_b_id, 0);

        // squash the second branch and the two younger ones with it
        cycle_start();
        br_task  = BR_SQUASH;
        rem_b_id = 4'b0010;
        cycle_end();
        compare_value("recover_valid", recover_valid, 1);
        compare_value("recover_pc", recover_pc, 32'h1004);
        compare_value("recover_fl_head", recover_fl_head, 2);
        compare_value("recover_rob_tail", recover_rob_tail, 3);
        for (int i = 0; i < `ARCH_REGS; i++) begin
            cycle_start();
            src_arch = 3'(i);
            cycle_end();
        end
        cycle_start();
        send_branch(32'h3000, 4, 5);
        cycle_end();
        compare_value("assigned_b_id", assigned_b_id, 4'b0010);

        // clear the middle branch, then squash the youngest
        drain_stack();
        for (int n = 0; n < 3; n++) begin
            cycle_start();
            send_branch(32'h4000 + 4 * n, n, n);
            cycle_end();
        end
        cycle_start();
        br_task  = BR_CLEAR;
        rem_b_id = 4'b0010;
        cycle_end();
        cycle_start();
        br_task  = BR_SQUASH;
        rem_b_id = 4'b0100;
        cycle_end();
        compare_value("recover_pc", recover_pc, 32'h4008);
        for (int n = 0; n < 3; n++) begin
            cycle_start();
            send_branch(32'h5000 + 4 * n, 0, 0);
            cycle_end();
            compare_value("assigned_b_id", assigned_b_id, 2 << n);
        end
        cycle_start();
        cycle_end();
        compare_value("full", full, 1);  // oldest branch survived

        // CDB wakeup reaches snapshots and the restore in the squash cycle
        drain_stack();
        cycle_start();
        rename_valid = 1'b1;
        rename_arch  = 3'd3;
        rename_preg  = 4'd12;
        cycle_end();
        cycle_start();
        send_branch(32'h6000, 1, 1);
        cycle_end();
        cycle_start();
        cdb[0] = '{valid: 1'b1, arch_idx: 3'd3, preg: 4'd12};
        cycle_end();
        cycle_start();
        src_arch     = 3'd3;
        rename_valid = 1'b1;
        rename_arch  = 3'd5;
        rename_preg  = 4'd13;
        cycle_end();
        compare_value("src_preg", src_preg, 12);
        compare_value("src_ready", src_ready, 1);
        cycle_start();
        send_branch(32'h6100, 2, 2);
        cycle_end();
        cycle_start();
        rename_valid = 1'b1;
        rename_arch  = 3'd5;
        rename_preg  = 4'd14;
        cycle_end();
        cycle_start();
        br_task  = BR_SQUASH;
        rem_b_id = 4'b0010;
        cdb[1]   = '{valid: 1'b1, arch_idx: 3'd5, preg: 4'd13};
        cycle_end();
        cycle_start();
        src_arch = 3'd5;
        cycle_end();
        compare_value("src_preg", src_preg, 13);
        compare_value("src_ready", src_ready, 1);
        cycle_start();
        br_task  = BR_SQUASH;
        rem_b_id = 4'b0001;
        cycle_end();
        cycle_start();
        src_arch = 3'd3;
        cycle_end();
        compare_value("src_preg", src_preg, 12);
        compare_value("src_ready", src_ready, 1);

        // random traffic against the model
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            cycle_start();
            drive_random();
            cycle_end();
        end

        // the assertions see the last random cycle at the next edge
        cycle_start();
        cycle_end();

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 8.0  // ns
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2.0) clock = ~clock;
    end

endmodule

//--- verilog/br_pkg.sv
`include "br_settings.svh"

package br_pkg;

    // task requested from the branch unit for one cycle
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_CLEAR  = 2'd1,  // branch resolved as predicted
        BR_SQUASH = 2'd2   // roll back after a mispredict
    } br_task_e;

    typedef struct packed {
        logic [`PREG_W-1:0] preg;
        logic               ready;
    } map_entry_t;

    typedef map_entry_t [`ARCH_REGS-1:0] map_array_t;

    typedef struct packed {
        logic               valid;
        logic [`ARCH_W-1:0] arch_idx;
        logic [`PREG_W-1:0] preg;
    } cdb_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [`BR_DEPTH-1:0] b_id;     // one-hot slot id
        logic [`BR_DEPTH-1:0] b_mask;   // own id plus every older live branch
        logic [`ADDR_W-1:0]   rec_pc;
        map_array_t           rec_mt;
        logic [`FL_W-1:0]     fl_head;
        logic [`ROB_W-1:0]    rob_tail;
    } checkpoint_t;

endpackage

//--- verilog/br_recovery_top.sv
`timescale 1ns/1ps
`include "br_settings.svh"

module br_recovery_top (
    input  logic                                        clock,
    input  logic                                        reset,

    input  logic                                        dispatch_valid,
    input  logic                                        dispatch_is_branch,
    input  logic [`ADDR_W-1:0]                          dispatch_pc,

    input  logic                                        rename_valid,
    input  logic [`ARCH_W-1:0]                          rename_arch,
    input  logic [`PREG_W-1:0]                          rename_preg,

    input  logic [`FL_W-1:0]                            fl_head,
    input  logic [`ROB_W-1:0]                           rob_tail,

    input  br_pkg::cdb_packet_t [`CDB_WIDTH-1:0]        cdb,

    input  br_pkg::br_task_e                            br_task,
    input  logic [`BR_DEPTH-1:0]                        rem_b_id,

    input  logic [`ARCH_W-1:0]                          src_arch,

    output logic [`BR_DEPTH-1:0]                        assigned_b_id,
    output logic                                        full,

    output logic                                        recover_valid,
    output logic [`ADDR_W-1:0]                          recover_pc,
    output logic [`FL_W-1:0]                            recover_fl_head,
    output logic [`ROB_W-1:0]                           recover_rob_tail,

    output logic [`PREG_W-1:0]                          src_preg,
    output logic                                        src_ready
);
    import br_pkg::*;

    map_array_t live_mt;

    recover_if rec_if ();

    map_table i_map_table (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_arch  (rename_arch),
        .rename_preg  (rename_preg),
        .cdb          (cdb),
        .src_arch     (src_arch),
        .src_preg     (src_preg),
        .src_ready    (src_ready),
        .live_mt      (live_mt),
        .rec          (rec_if.map)
    );

    br_stack i_br_stack (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dispatch_is_branch (dispatch_is_branch),
        .dispatch_pc        (dispatch_pc),
        .live_mt            (live_mt),
        .fl_head            (fl_head),
        .rob_tail           (rob_tail),
        .cdb                (cdb),
        .br_task            (br_task),
        .rem_b_id           (rem_b_id),
        .assigned_b_id      (assigned_b_id),
        .full               (full),
        .rec                (rec_if.stack)
    );

    // recovery values for the free list, ROB and fetch
    assign recover_valid    = rec_if.restore;
    assign recover_pc       = rec_if.rec_pc;
    assign recover_fl_head  = rec_if.fl_head;
    assign recover_rob_tail = rec_if.rob_tail;

endmodule

//--- verilog/br_settings.svh
`ifndef BR_SETTINGS_SVH
`define BR_SETTINGS_SVH

// checkpoint depth, also the width of the one-hot b_id and b_mask
`define BR_DEPTH 4

`define ARCH_REGS 8
`define PHYS_REGS 16
`define ROB_SZ 16
`define CDB_WIDTH 2
`define ADDR_W 32

// derived index widths
`define ARCH_W $clog2(`ARCH_REGS)
`define PREG_W $clog2(`PHYS_REGS)
`define FL_W $clog2(`PHYS_REGS + 1)   // free-list head counts one past the last reg
`define ROB_W $clog2(`ROB_SZ)

`endif

//--- verilog/br_stack.sv
`timescale 1ns/1ps
`include "br_settings.svh"

module br_stack (
    input  logic                                        clock,
    input  logic                                        reset,

    input  logic                                        dispatch_valid,
    input  logic                                        dispatch_is_branch,
    input  logic [`ADDR_W-1:0]                          dispatch_pc,

    input  br_pkg::map_array_t                          live_mt,
    input  logic [`FL_W-1:0]                            fl_head,
    input  logic [`ROB_W-1:0]                           rob_tail,

    input  br_pkg::cdb_packet_t [`CDB_WIDTH-1:0]        cdb,

    input  br_pkg::br_task_e                            br_task,
    input  logic [`BR_DEPTH-1:0]                        rem_b_id,  // one-hot

    output logic [`BR_DEPTH-1:0]                        assigned_b_id,
    output logic                                        full,
    recover_if.stack                                    rec
);
    import br_pkg::*;

    checkpoint_t [`BR_DEPTH-1:0] entries;
    checkpoint_t [`BR_DEPTH-1:0] next_entries;

    logic [`BR_DEPTH-1:0] free_map;       // 1 = slot free
    logic [`BR_DEPTH-1:0] next_free_map;
    logic [`BR_DEPTH-1:0] grant;
    logic                 no_free;
    logic                 do_alloc;
    logic [`BR_DEPTH-1:0] new_mask;
    checkpoint_t          sel_cp;        // entry named by rem_b_id

    psel_gen #(
        .WIDTH(`BR_DEPTH)
    ) i_psel (
        .req   (free_map),
        .gnt   (grant),
        .empty (no_free)
    );

    assign full = no_free;

    // no allocation while full or while the pipeline is being squashed
    assign do_alloc      = dispatch_valid && dispatch_is_branch && !full &&
                           (br_task != BR_SQUASH);
    assign assigned_b_id = do_alloc ? grant : '0;

    // new branch depends on itself and on every older branch still live after a clear
    always_comb begin
        new_mask = grant;
        for (int i = 0; i < `BR_DEPTH; i++) begin
            if (entries[i].valid &&
                !(br_task == BR_CLEAR && entries[i].b_id == rem_b_id)) begin
                new_mask |= entries[i].b_id;
            end
        end
    end

    always_comb begin
        sel_cp = '0;
        for (int i = 0; i < `BR_DEPTH; i++) begin
            if (entries[i].valid && entries[i].b_id == rem_b_id) begin
                sel_cp = entries[i];
            end
        end
    end

    // the CDB of this cycle is merged into the restored map in map_table
    assign rec.restore  = (br_task == BR_SQUASH) && sel_cp.valid;
    assign rec.rec_mt   = sel_cp.rec_mt;
    assign rec.rec_pc   = sel_cp.rec_pc;
    assign rec.fl_head  = sel_cp.fl_head;
    assign rec.rob_tail = sel_cp.rob_tail;

    always_comb begin
        next_entries  = entries;
        next_free_map = free_map;

        // keep snapshot ready bits current
        for (int j = 0; j < `BR_DEPTH; j++) begin
            for (int l = 0; l < `CDB_WIDTH; l++) begin
                if (cdb[l].valid && entries[j].valid &&
                    entries[j].rec_mt[cdb[l].arch_idx].preg == cdb[l].preg) begin
                    next_entries[j].rec_mt[cdb[l].arch_idx].ready = 1'b1;
                end
            end
        end

        case (br_task)
            BR_CLEAR: begin
                for (int i = 0; i < `BR_DEPTH; i++) begin
                    if (entries[i].valid) begin
                        if (entries[i].b_id == rem_b_id) begin
                            next_entries[i]  = '0;
                            next_free_map[i] = 1'b1;
                        end else begin
                            next_entries[i].b_mask = entries[i].b_mask & ~rem_b_id;
                        end
                    end
                end
            end
            BR_SQUASH: begin
                // the branch itself and everything younger
                for (int i = 0; i < `BR_DEPTH; i++) begin
                    if (entries[i].valid && |(entries[i].b_mask & rem_b_id)) begin
                        next_entries[i]  = '0;
                        next_free_map[i] = 1'b1;
                    end
                end
            end
            default: ;
        endcase

        if (do_alloc) begin
            for (int k = 0; k < `BR_DEPTH; k++) begin
                if (grant[k]) begin
                    next_entries[k].valid    = 1'b1;
                    next_entries[k].b_id     = grant;
                    next_entries[k].b_mask   = new_mask;
                    next_entries[k].rec_pc   = dispatch_pc;
                    next_entries[k].rec_mt   = live_mt;  // map before this edge
                    next_entries[k].fl_head  = fl_head;
                    next_entries[k].rob_tail = rob_tail;
                    next_free_map[k]         = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries  <= '0;
            free_map <= '1;
        end else begin
            entries  <= next_entries;
            free_map <= next_free_map;
        end
    end

endmodule

//--- verilog/map_table.sv
`timescale 1ns/1ps
`include "br_settings.svh"

module map_table (
    input  logic                                        clock,
    input  logic                                        reset,

    input  logic                                        rename_valid,
    input  logic [`ARCH_W-1:0]                          rename_arch,
    input  logic [`PREG_W-1:0]                          rename_preg,

    input  br_pkg::cdb_packet_t [`CDB_WIDTH-1:0]        cdb,

    input  logic [`ARCH_W-1:0]                          src_arch,
    output logic [`PREG_W-1:0]                          src_preg,
    output logic                                        src_ready,

    output br_pkg::map_array_t                          live_mt,
    recover_if.map                                      rec
);
    import br_pkg::*;

    map_array_t mt;
    map_array_t next_mt;

    // restore picks the base before CDB wakeups, and rename is applied last
    always_comb begin
        next_mt = rec.restore ? rec.rec_mt : mt;

        for (int l = 0; l < `CDB_WIDTH; l++) begin
            if (cdb[l].valid && next_mt[cdb[l].arch_idx].preg == cdb[l].preg) begin
                next_mt[cdb[l].arch_idx].ready = 1'b1;
            end
        end

        // rename belongs to the wrong path during a squash
        if (rename_valid && !rec.restore) begin
            next_mt[rename_arch].preg  = rename_preg;
            next_mt[rename_arch].ready = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                mt[i].preg  <= i[`PREG_W-1:0];  // identity map
                mt[i].ready <= 1'b1;
            end
        end else begin
            mt <= next_mt;
        end
    end

    assign src_preg  = mt[src_arch].preg;
    assign src_ready = mt[src_arch].ready;

    assign live_mt = mt;  // snapshot source for br_stack

endmodule

//--- verilog/psel_gen.sv
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic             empty
);

    // scan from the top so the lowest set bit is the last one written
    always_comb begin
        gnt = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
            end
        end
    end

    assign empty = ~|req;

endmodule

//--- verilog/recover_if.sv
`timescale 1ns/1ps
`include "br_settings.svh"

interface recover_if;
    import br_pkg::*;

    logic               restore;   // squash in progress this cycle
    map_array_t         rec_mt;
    logic [`ADDR_W-1:0] rec_pc;
    logic [`FL_W-1:0]   fl_head;
    logic [`ROB_W-1:0]  rob_tail;

    modport stack (
        output restore, rec_mt, rec_pc, fl_head, rob_tail
    );

    // map side only loads the map, the rest is forwarded to the core
    modport map (
        input restore, rec_mt, rec_pc, fl_head, rob_tail
    );

endinterface
